// File: rtl/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  localparam int CMD_WIDTH  = 16;
  localparam int CMD_RW_BIT = 15; // 1 = write, 0 = read.
  localparam int FRAME_BITS = 11; // Start, 8 data, parity, stop.

  typedef logic [7:0]           byte_t;
  typedef logic [CMD_WIDTH-1:0] cmd_t;

  // Even parity bit for one data byte.
  function automatic logic even_parity(input byte_t data);
    return ^data;
  endfunction

endpackage

`default_nettype wire

// File: rtl/uart_tx_frame.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx_frame #(
  parameter int BAUD_DIV = 434
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                tx_start,
  input  wire uart_cmd_pkg::byte_t tx_byte,
  output logic                     tx,
  output logic                     tx_done
);
  import uart_cmd_pkg::*;

  localparam int               CNT_W     = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BAUD_DIV - 1);
  localparam logic [3:0]       STOP_IDX  = 4'(FRAME_BITS - 1);

  logic                    busy;
  logic [CNT_W-1:0]        baud_cnt;
  logic [3:0]              bit_cnt;
  logic [FRAME_BITS-2:0]   shift_q; // Stop, parity, data.
  logic                    bit_end;

  assign bit_end = busy && (baud_cnt == BAUD_LAST);
  assign tx_done = bit_end && (bit_cnt == STOP_IDX); // Last cycle of stop bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else if (tx_start)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b0; // Start bit.
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        if (bit_cnt == STOP_IDX)
        begin
          busy <= 1'b0;
        end
        else
        begin
          bit_cnt <= bit_cnt + 4'd1;
          tx      <= shift_q[0];
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // Frame payload shifts out LSB first, ones fill behind.
  always_ff @(posedge clk)
  begin
    if (tx_start)
      shift_q <= {1'b1, even_parity(tx_byte), tx_byte};
    else if (bit_end)
      shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
  end

endmodule

`default_nettype wire

// File: rtl/uart_rx_frame.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_frame #(
  parameter int BAUD_DIV = 434
) (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           rx,
  input  wire logic           rx_enable,
  output logic                rx_busy,
  output logic                rx_valid,
  output uart_cmd_pkg::byte_t rx_byte,
  output logic                rx_err
);
  import uart_cmd_pkg::*;

  localparam int               CNT_W     = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] HALF      = CNT_W'(BAUD_DIV / 2);
  localparam logic [3:0]       PAR_IDX   = 4'(FRAME_BITS - 2);
  localparam logic [3:0]       STOP_IDX  = 4'(FRAME_BITS - 1);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic             par_q;
  logic             sample;

  assign sample = rx_busy && (baud_cnt == HALF); // Mid-bit point.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_busy  <= 1'b0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      if (!rx_busy)
      begin
        if (rx_enable && rx_prev && !rx_sync) // Falling edge.
        begin
          rx_busy  <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end
      else
      begin
        baud_cnt <= (baud_cnt == BAUD_LAST) ? '0 : baud_cnt + 1'b1;
        if (baud_cnt == BAUD_LAST)
          bit_cnt <= bit_cnt + 4'd1;
        if (sample && (bit_cnt == '0) && rx_sync)
        begin
          rx_busy <= 1'b0; // Glitch, not a start bit.
        end
        else if (sample && (bit_cnt == STOP_IDX))
        begin
          rx_busy <= 1'b0;
          if (rx_sync && (par_q == even_parity(rx_byte)))
            rx_valid <= 1'b1;
          else
            rx_err <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && (bit_cnt != '0) && (bit_cnt < PAR_IDX))
      rx_byte <= {rx_sync, rx_byte[7:1]}; // LSB arrives first.
    if (sample && (bit_cnt == PAR_IDX))
      par_q <= rx_sync;
  end

endmodule

`default_nettype wire

// File: rtl/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer #(
  parameter int BAUD_DIV  = 434,
  parameter int GAP_BITS  = 16,
  parameter int RESP_BITS = 32
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_cmd_pkg::cmd_t  cmd_in,
  input  wire logic                cmd_vld,
  input  wire logic                tx_done,
  input  wire logic                rx_busy,
  input  wire logic                rx_valid,
  input  wire uart_cmd_pkg::byte_t rx_byte,
  input  wire logic                rx_err,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output uart_cmd_pkg::byte_t      tx_byte,
  output logic                     rx_enable,
  output logic                     read_rdy,
  output uart_cmd_pkg::byte_t      read_data,
  output logic                     read_err
);
  import uart_cmd_pkg::*;

  localparam int GAP_CYC  = GAP_BITS * BAUD_DIV;
  localparam int RESP_CYC = RESP_BITS * BAUD_DIV;
  localparam int CNT_W    = $clog2(((GAP_CYC > RESP_CYC) ? GAP_CYC : RESP_CYC) + 1);
  // Down counter, terminal count zero.
  localparam logic [CNT_W-1:0] GAP_LOAD  = CNT_W'(GAP_CYC - 2);
  localparam logic [CNT_W-1:0] RESP_LOAD = CNT_W'(RESP_CYC - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND1,
    S_GAP,
    S_SEND2,
    S_WAIT_RESP,
    S_RECEIVE,
    S_REPORT
  } state_t;

  state_t           state;
  cmd_t             cmd_q;
  logic [CNT_W-1:0] cnt;

  assign cmd_rdy   = (state == S_IDLE);
  assign rx_enable = (state == S_WAIT_RESP) || (state == S_RECEIVE);
  assign tx_byte   = (state == S_SEND2) ? cmd_q[7:0] : cmd_q[CMD_WIDTH-1 -: 8];

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
      cmd_q <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      cnt       <= '0;
      tx_start  <= 1'b0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (cmd_vld)
          begin
            tx_start <= 1'b1;
            state    <= S_SEND1;
          end
        end
        S_SEND1:
        begin
          if (tx_done && cmd_q[CMD_RW_BIT])
          begin
            cnt   <= GAP_LOAD;
            state <= S_GAP;
          end
          else if (tx_done)
          begin
            cnt   <= RESP_LOAD;
            state <= S_WAIT_RESP;
          end
        end
        S_GAP:
        begin
          cnt <= cnt - 1'b1;
          if (cnt == '0)
          begin
            tx_start <= 1'b1;
            state    <= S_SEND2;
          end
        end
        S_SEND2:
        begin
          if (tx_done)
            state <= S_IDLE;
        end
        S_WAIT_RESP:
        begin
          if (rx_busy)
          begin
            state <= S_RECEIVE;
          end
          else if (cnt == '0)
          begin
            read_err <= 1'b1; // No response in window.
            state    <= S_REPORT;
          end
          else
          begin
            cnt <= cnt - 1'b1;
          end
        end
        S_RECEIVE:
        begin
          if (rx_valid)
          begin
            read_rdy  <= 1'b1;
            read_data <= rx_byte;
            state     <= S_REPORT;
          end
          else if (rx_err)
          begin
            read_err <= 1'b1;
            state    <= S_REPORT;
          end
          else if (!rx_busy)
          begin
            state <= S_WAIT_RESP; // False start, window resumes.
          end
        end
        S_REPORT:  state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_cmd_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_top #(
  parameter int BAUD_DIV  = 434,
  parameter int GAP_BITS  = 16,
  parameter int RESP_BITS = 32
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_cmd_pkg::cmd_t  cmd_in,
  input  wire logic                cmd_vld,
  input  wire logic                rx,
  output wire logic                tx,
  output wire logic                cmd_rdy,
  output wire logic                read_rdy,
  output wire uart_cmd_pkg::byte_t read_data,
  output wire logic                read_err
);
  import uart_cmd_pkg::*;

  wire        tx_start;
  wire        tx_done;
  wire byte_t tx_byte;
  wire        rx_enable;
  wire        rx_busy;
  wire        rx_valid;
  wire        rx_err;
  wire byte_t rx_byte;

  cmd_sequencer #(
    .BAUD_DIV  (BAUD_DIV),
    .GAP_BITS  (GAP_BITS),
    .RESP_BITS (RESP_BITS)
  ) cmd_sequencer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_done   (tx_done),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .rx_enable (rx_enable),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame #(
    .BAUD_DIV (BAUD_DIV)
  ) uart_tx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame #(
    .BAUD_DIV (BAUD_DIV)
  ) uart_rx_frame_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_enable (rx_enable),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err)
  );

endmodule

`default_nettype wire

// File: test/uart_cmd_sva.sv
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_sva (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic tx,
  input wire logic cmd_vld,
  input wire logic cmd_rdy,
  input wire logic read_rdy,
  input wire logic read_err
);

  // Line idles high while the host side waits.
  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

  pulses_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_rdy && read_err))
    else $error("read_rdy and read_err high together");

  accept_drops_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy still high after an accepted command");

endmodule

bind uart_cmd_top uart_cmd_sva uart_cmd_sva_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx       (tx),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy),
  .read_err (read_err)
);

`default_nettype wire

// File: test/tb_uart_cmd.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart_cmd;
  import uart_cmd_pkg::*;

  localparam int BAUD_DIV   = 16;
  localparam int GAP_BITS   = 16;
  localparam int RESP_BITS  = 32;
  localparam int CLK_PERIOD = 100;
  localparam int CMD_CYCLES = (2 * FRAME_BITS + GAP_BITS + RESP_BITS) * BAUD_DIV;
  localparam int MAX_CYCLES = 14 * CMD_CYCLES * 2; // Double the command budget.
  localparam int RESP_GOOD   = 0;
  localparam int RESP_BADPAR = 1;
  localparam int RESP_SILENT = 2;

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  rx;
  logic  tx;
  logic  cmd_rdy;
  logic  read_rdy;
  byte_t read_data;
  logic  read_err;

  int     errors;
  int     cycles;
  int     seed;
  int     rdy_cnt;
  int     err_cnt;
  byte_t  rdy_data;
  longint err_time;

  uart_cmd_top #(
    .BAUD_DIV  (BAUD_DIV),
    .GAP_BITS  (GAP_BITS),
    .RESP_BITS (RESP_BITS)
  ) uart_cmd_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, errors: %0d", cycles, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  // Host-side pulse monitor.
  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      rdy_cnt  = rdy_cnt + 1;
      rdy_data = read_data;
    end
    if (rst_n && read_err)
    begin
      err_cnt  = err_cnt + 1;
      err_time = $time;
    end
  end

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act)
    begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic check_cmd_rdy(input logic exp);
    check_bit("cmd_rdy", exp, cmd_rdy);
  endtask

  task automatic check_pulses(input int exp_rdy, input int exp_err);
    if (rdy_cnt != exp_rdy || err_cnt != exp_err)
    begin
      $display("At %0t read_rdy pulsed %0d times and read_err %0d times, expected %0d and %0d",
               $time, rdy_cnt, err_cnt, exp_rdy, exp_err);
      errors = errors + 1;
    end
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < limit)
    begin
      @(negedge clk);
      n = n + 1;
    end
    if (!cmd_rdy)
    begin
      $display("At %0t cmd_rdy did not return high within %0d cycles", $time, limit);
      errors = errors + 1;
    end
  endtask

  task automatic issue_cmd(input cmd_t c);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  // Samples one frame on tx at mid-bit.
  task automatic receive_tx(output byte_t data, output logic par, output logic stop,
                            output longint t_fall);
    int i;
    @(negedge tx);
    t_fall = $time;
    repeat (BAUD_DIV / 2) @(negedge clk);
    if (tx !== 1'b0)
    begin
      $display("At %0t start bit on tx was not held low", $time);
      errors = errors + 1;
    end
    for (i = 0; i < 8; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      data[i] = tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    par = tx;
    repeat (BAUD_DIV) @(negedge clk);
    stop = tx;
  endtask

  task automatic send_rx(input byte_t data, input int mode);
    int   i;
    logic par;
    par = even_parity(data) ^ (mode == RESP_BADPAR);
    if (mode != RESP_SILENT)
    begin
      @(posedge clk);
      rx <= 1'b0;
      repeat (BAUD_DIV) @(posedge clk);
      for (i = 0; i < 8; i++)
      begin
        rx <= data[i];
        repeat (BAUD_DIV) @(posedge clk);
      end
      rx <= par;
      repeat (BAUD_DIV) @(posedge clk);
      rx <= 1'b1;
      repeat (BAUD_DIV) @(posedge clk);
    end
  endtask

  task automatic check_frame(input string name, input byte_t exp, input byte_t data,
                             input logic par, input logic stop);
    int   i;
    int   ones;
    logic exp_par;
    ones = 0;
    for (i = 0; i < 8; i++)
      ones = ones + exp[i];
    exp_par = (ones % 2) == 1; // Parity bit evens out the ones.
    check_byte(name, exp, data);
    check_bit({name, " parity"}, exp_par, par);
    check_bit({name, " stop"}, 1'b1, stop);
  endtask

  task automatic run_write(input cmd_t c, input bit intrude);
    byte_t  data;
    logic   par;
    logic   stop;
    longint t1;
    longint t2;
    longint idle;
    int     n;
    wait_idle(CMD_CYCLES);
    rdy_cnt = 0;
    err_cnt = 0;
    issue_cmd(c);
    receive_tx(data, par, stop, t1);
    check_frame("tx upper byte", c[15:8], data, par, stop);
    if (intrude)
      issue_cmd(16'h0055); // Lands while busy.
    receive_tx(data, par, stop, t2);
    check_frame("tx lower byte", c[7:0], data, par, stop);
    idle = (t2 - t1) / CLK_PERIOD - FRAME_BITS * BAUD_DIV;
    if (idle < GAP_BITS * BAUD_DIV)
    begin
      $display("At %0t write gap was only %0d cycles", $time, idle);
      errors = errors + 1;
    end
    wait_idle(4 * BAUD_DIV);
    check_cmd_rdy(1'b1);
    if (intrude)
    begin
      for (n = 0; n < 2 * FRAME_BITS * BAUD_DIV; n++)
      begin
        @(negedge clk);
        if (!tx || !cmd_rdy)
        begin
          $display("At %0t the ignored command started a transfer", $time);
          errors = errors + 1;
          break;
        end
      end
    end
    check_pulses(0, 0);
  endtask

  task automatic run_read(input cmd_t c, input int mode);
    byte_t  data;
    byte_t  resp;
    byte_t  prev;
    logic   par;
    logic   stop;
    longint t1;
    wait_idle(CMD_CYCLES);
    rdy_cnt = 0;
    err_cnt = 0;
    prev = read_data;
    resp = byte_t'($random(seed));
    issue_cmd(c);
    receive_tx(data, par, stop, t1);
    check_frame("tx address byte", c[15:8], data, par, stop);
    repeat (BAUD_DIV) @(posedge clk); // Past the stop bit.
    send_rx(resp, mode);
    wait_idle(CMD_CYCLES);
    check_cmd_rdy(1'b1);
    if (mode == RESP_GOOD)
    begin
      check_pulses(1, 0);
      check_byte("read_data", resp, rdy_data);
      check_byte("read_data", resp, read_data);
    end
    else
    begin
      check_pulses(0, 1);
      check_byte("read_data", prev, read_data);
    end
    if (mode == RESP_SILENT &&
        err_time - t1 < (FRAME_BITS + RESP_BITS) * BAUD_DIV * CLK_PERIOD)
    begin
      $display("At %0t read_err came before the response window ended", $time);
      errors = errors + 1;
    end
  endtask

  task automatic run_random(input int count);
    cmd_t c;
    int   k;
    for (k = 0; k < count; k++)
    begin
      c = cmd_t'($random(seed));
      if (c[CMD_RW_BIT])
        run_write(c, 1'b0);
      else
        run_read(c, RESP_GOOD);
    end
  endtask

  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    errors  = 0;
    cycles  = 0;
    seed    = 20;
    rdy_cnt = 0;
    err_cnt = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    run_write(16'hA53C, 1'b0);
    run_read(16'h1200, RESP_GOOD);
    run_read(16'h3400, RESP_BADPAR);
    run_read(16'h5600, RESP_SILENT);
    run_write(16'hC381, 1'b1);
    run_random(8);

    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rtl/uart_cmd_pkg.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/cmd_sequencer.sv
rtl/uart_cmd_top.sv
test/uart_cmd_sva.sv
test/tb_uart_cmd.sv
